/* list.f */
hw/mem_pkg.sv
hw/byte_ram.sv
hw/mem_ctrl.sv
hw/fetch_unit.sv
hw/mem_subsys.sv
testbench/mem_checker.sv
testbench/tb_mem_subsys.sv

/* run.sh */
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_mem_subsys -o tb_mem_subsys

./obj_dir/tb_mem_subsys > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without failures"

/* testbench/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;

	localparam int				ADDR_W = 10;
	localparam mem_pkg::addr_t	RESET_PC = 32'h0000_0000;
	localparam int				DEPTH = 2 ** ADDR_W;
	localparam int				TIMEOUT = 200;
	localparam int				OPS = 400;

	logic				clk = 1'b0;
	logic				rst = 1'b1;
	logic				fetch_en = 1'b0;
	logic				redirect = 1'b0;
	mem_pkg::addr_t		redirect_pc = '0;
	logic				data_req = 1'b0;
	logic				data_wr = 1'b0;
	mem_pkg::addr_t		data_addr = '0;
	mem_pkg::word_t		data_wdata = '0;

	logic				instr_valid;
	mem_pkg::word_t		instr;
	mem_pkg::addr_t		instr_pc;
	logic				data_done;
	mem_pkg::word_t		data_rdata;

	int					errors;
	int					checks;
	int					timeouts = 0;

	always #4 clk = ~clk;

	mem_subsys #(
		.ADDR_W		(ADDR_W),
		.RESET_PC	(RESET_PC)
	) mem_subsys_i (
		.clk_i			(clk),
		.rst_i			(rst),
		.fetch_en_i		(fetch_en),
		.redirect_i		(redirect),
		.redirect_pc_i	(redirect_pc),
		.data_req_i		(data_req),
		.data_wr_i		(data_wr),
		.data_addr_i	(data_addr),
		.data_wdata_i	(data_wdata),
		.instr_valid_o	(instr_valid),
		.instr_o		(instr),
		.instr_pc_o		(instr_pc),
		.data_done_o	(data_done),
		.data_rdata_o	(data_rdata)
	);

	mem_checker #(
		.ADDR_W		(ADDR_W),
		.RESET_PC	(RESET_PC)
	) mem_checker_i (
		.clk_i			(clk),
		.rst_i			(rst),
		.redirect_i		(redirect),
		.redirect_pc_i	(redirect_pc),
		.data_req_i		(data_req),
		.data_wr_i		(data_wr),
		.data_addr_i	(data_addr),
		.data_wdata_i	(data_wdata),
		.instr_valid_i	(instr_valid),
		.instr_i		(instr),
		.instr_pc_i		(instr_pc),
		.data_done_i	(data_done),
		.data_rdata_i	(data_rdata),
		.errors_o		(errors),
		.checks_o		(checks)
	);

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_data_done();
		int cycles;
		cycles = 0;
		while (!data_done && cycles < TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!data_done) begin
			timeouts++;
			$display("no data done strobe within %0d cycles at %0t", TIMEOUT, $time);
		end
	endtask

	task automatic wait_instr();
		int cycles;
		cycles = 0;
		while (!instr_valid && cycles < TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!instr_valid) begin
			timeouts++;
			$display("no instruction delivered within %0d cycles at %0t", TIMEOUT, $time);
		end
	endtask

	task automatic data_access(input logic wr, input mem_pkg::addr_t addr,
		input mem_pkg::word_t wdata);
		data_req = 1'b1;
		data_wr = wr;
		data_addr = addr;
		data_wdata = wdata;
		@(posedge clk);
		#1;
		data_req = 1'b0; // one-cycle strobe
		wait_data_done();
	endtask

	task automatic redirect_to(input mem_pkg::addr_t target);
		redirect = 1'b1;
		redirect_pc = target;
		@(posedge clk);
		#1;
		redirect = 1'b0;
		wait_instr(); // the checker expects the target as the next pc
	endtask

	task automatic run_stimulus();
		int kind;
		mem_pkg::addr_t addr;
		for (int a = 0; a < DEPTH; a += 4) begin
			data_access(1'b1, mem_pkg::addr_t'(a), $urandom());
			if (timeouts != 0) return;
		end
		for (int n = 0; n < 32; n++) begin
			data_access(1'b0, $urandom() & 32'hffff_fffc, '0);
			if (timeouts != 0) return;
		end
		fetch_en = 1'b1;
		wait_instr();
		if (timeouts != 0) return;
		// fetch keeps running while data traffic and redirects compete for the ram
		for (int n = 0; n < OPS; n++) begin
			kind = $urandom_range(9, 0);
			addr = $urandom() & 32'hffff_fffc; // upper bits exercise the address wrap
			if (kind < 4) begin
				data_access(1'b0, addr, '0);
			end else if (kind < 7) begin
				data_access(1'b1, addr, $urandom());
			end else if (kind == 7) begin
				redirect_to(addr & 32'h0000_0ffc);
			end else begin
				idle_cycles($urandom_range(8, 1));
			end
			if (timeouts != 0) return;
		end
	endtask

	initial begin
		void'($urandom(32'h6812e329));
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		run_stimulus();
		fetch_en = 1'b0;
		idle_cycles(20);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* testbench/mem_checker.sv */
`timescale 1ns/1ps

module mem_checker #(
	parameter int				ADDR_W = 10,
	parameter mem_pkg::addr_t	RESET_PC = '0
) (
	input	logic				clk_i,
	input	logic				rst_i,
	input	logic				redirect_i,
	input	mem_pkg::addr_t		redirect_pc_i,
	input	logic				data_req_i,
	input	logic				data_wr_i,
	input	mem_pkg::addr_t		data_addr_i,
	input	mem_pkg::word_t		data_wdata_i,
	input	logic				instr_valid_i,
	input	mem_pkg::word_t		instr_i,
	input	mem_pkg::addr_t		instr_pc_i,
	input	logic				data_done_i,
	input	mem_pkg::word_t		data_rdata_i,
	output	int					errors_o,
	output	int					checks_o
);

	mem_pkg::byte_t		model [2**ADDR_W];
	mem_pkg::addr_t		exp_pc = RESET_PC;
	logic				rst_q = 1'b0;
	logic				pend = 1'b0;
	logic				pend_wr = 1'b0;
	mem_pkg::addr_t		pend_addr = '0;
	mem_pkg::word_t		pend_wdata = '0;
	int					errors = 0;
	int					checks = 0;

	assign errors_o = errors;
	assign checks_o = checks;

	// only the low ADDR_W bits select a byte, so addresses wrap around the ram
	function automatic logic [ADDR_W-1:0] byte_index(mem_pkg::addr_t addr, int offset);
		mem_pkg::addr_t sum;
		sum = addr + mem_pkg::addr_t'(offset);
		return sum[ADDR_W-1:0];
	endfunction

	function automatic mem_pkg::word_t model_word(mem_pkg::addr_t addr);
		mem_pkg::word_t w;
		w = '0;
		for (int i = 0; i < 4; i++) begin
			w = {w[23:0], model[byte_index(addr, i)]}; // lowest address lands in the top byte
		end
		return w;
	endfunction

	task automatic compare(input string name, input mem_pkg::word_t exp,
		input mem_pkg::word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s at %0t: expected %h, actual %h", name, $time, exp, act);
		end
	endtask

	// outputs are sampled mid-cycle, well clear of the rising edge
	always @(negedge clk_i) begin
		if (rst_i || rst_q) begin
			compare("reset_instr_valid", '0, mem_pkg::word_t'(instr_valid_i));
			compare("reset_data_done", '0, mem_pkg::word_t'(data_done_i));
		end
		rst_q = rst_i;
		if (rst_i) begin
			exp_pc = RESET_PC;
			pend = 1'b0;
		end else begin
			if (instr_valid_i) begin
				compare("fetch_pc", exp_pc, instr_pc_i);
				compare("fetch_word", model_word(exp_pc), instr_i);
			end
			if (redirect_i) begin
				exp_pc = redirect_pc_i; // a word in flight is dropped, so the target comes next
			end else if (instr_valid_i) begin
				exp_pc = exp_pc + 32'd4;
			end
			if (data_done_i) begin
				if (!pend) begin
					errors++;
					$display("data done strobe at %0t with no data request outstanding", $time);
				end else if (pend_wr) begin
					for (int i = 0; i < 4; i++) begin
						model[byte_index(pend_addr, i)] = pend_wdata[8*(3-i) +: 8];
					end
				end else begin
					compare("read_back", model_word(pend_addr), data_rdata_i);
				end
				pend = 1'b0;
			end
			if (data_req_i) begin
				if (pend) begin
					errors++;
					$display("data request at %0t while another one is still open", $time);
				end
				pend = 1'b1;
				pend_wr = data_wr_i;
				pend_addr = data_addr_i;
				pend_wdata = data_wdata_i;
			end
		end
	end

endmodule

/* hw/mem_subsys.sv */
`timescale 1ns/1ps

module mem_subsys #(
	parameter int				ADDR_W = 10,
	parameter mem_pkg::addr_t	RESET_PC = '0
) (
	input	logic				clk_i,
	input	logic				rst_i,
	input	logic				fetch_en_i,
	input	logic				redirect_i,
	input	mem_pkg::addr_t		redirect_pc_i,
	input	logic				data_req_i,
	input	logic				data_wr_i,
	input	mem_pkg::addr_t		data_addr_i,
	input	mem_pkg::word_t		data_wdata_i,
	output	logic				instr_valid_o,
	output	mem_pkg::word_t		instr_o,
	output	mem_pkg::addr_t		instr_pc_o,
	output	logic				data_done_o,
	output	mem_pkg::word_t		data_rdata_o
);

	logic				if_req;
	mem_pkg::addr_t		if_addr;
	logic				if_done;
	mem_pkg::word_t		if_word;

	mem_pkg::addr_t		ram_addr;
	logic				ram_we;
	mem_pkg::byte_t		ram_wdata;
	mem_pkg::byte_t		ram_rdata;

	fetch_unit #(
		.RESET_PC	(RESET_PC)
	) fetch_unit_i (
		.clk_i			(clk_i),
		.rst_i			(rst_i),
		.fetch_en_i		(fetch_en_i),
		.redirect_i		(redirect_i),
		.redirect_pc_i	(redirect_pc_i),
		.if_done_i		(if_done),
		.if_word_i		(if_word),
		.if_req_o		(if_req),
		.if_addr_o		(if_addr),
		.instr_valid_o	(instr_valid_o),
		.instr_o		(instr_o),
		.instr_pc_o		(instr_pc_o)
	);

	mem_ctrl mem_ctrl_i (
		.clk_i			(clk_i),
		.rst_i			(rst_i),
		.if_req_i		(if_req),
		.if_addr_i		(if_addr),
		.data_req_i		(data_req_i),
		.data_wr_i		(data_wr_i),
		.data_addr_i	(data_addr_i),
		.data_wdata_i	(data_wdata_i),
		.ram_rdata_i	(ram_rdata),
		.if_done_o		(if_done),
		.if_word_o		(if_word),
		.data_done_o	(data_done_o),
		.data_rdata_o	(data_rdata_o),
		.ram_addr_o		(ram_addr),
		.ram_we_o		(ram_we),
		.ram_wdata_o	(ram_wdata)
	);

	byte_ram #(
		.ADDR_W	(ADDR_W)
	) byte_ram_i (
		.clk_i		(clk_i),
		.addr_i		(ram_addr),
		.we_i		(ram_we),
		.wdata_i	(ram_wdata),
		.rdata_o	(ram_rdata)
	);

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
	parameter mem_pkg::addr_t RESET_PC = '0
) (
	input	logic				clk_i,
	input	logic				rst_i,
	input	logic				fetch_en_i,
	input	logic				redirect_i,
	input	mem_pkg::addr_t		redirect_pc_i,
	input	logic				if_done_i,
	input	mem_pkg::word_t		if_word_i,
	output	logic				if_req_o,
	output	mem_pkg::addr_t		if_addr_o,
	output	logic				instr_valid_o,
	output	mem_pkg::word_t		instr_o,
	output	mem_pkg::addr_t		instr_pc_o
);

	mem_pkg::addr_t	pc_q;
	logic			busy_q;
	logic			req_q;
	logic			drop_q;
	logic			launch;
	logic			deliver;

	// busy covers the strobe cycle as well, so a second strobe cannot slip out
	assign launch = fetch_en_i && (!busy_q || if_done_i);

	// a redirect kills the word that is on its way back
	assign deliver = if_done_i && !drop_q && !redirect_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pc_q <= RESET_PC;
			busy_q <= 1'b0;
			req_q <= 1'b0;
			drop_q <= 1'b0;
		end else begin
			req_q <= launch;
			if (launch) begin
				busy_q <= 1'b1;
			end else if (if_done_i) begin
				busy_q <= 1'b0;
			end
			if (redirect_i) begin
				pc_q <= redirect_pc_i;
			end else if (deliver) begin
				pc_q <= pc_q + 32'd4;
			end
			if (if_done_i) begin
				drop_q <= 1'b0;
			end else if (redirect_i && busy_q) begin
				drop_q <= 1'b1;
			end
		end
	end

	assign if_req_o = req_q;
	assign if_addr_o = pc_q; // pc only moves once the word is back or on a redirect

	assign instr_valid_o = deliver;
	assign instr_o = if_word_i;
	assign instr_pc_o = pc_q;

endmodule

/* hw/mem_ctrl.sv */
`timescale 1ns/1ps

module mem_ctrl (
	input	logic				clk_i,
	input	logic				rst_i,
	input	logic				if_req_i,
	input	mem_pkg::addr_t		if_addr_i,
	input	logic				data_req_i,
	input	logic				data_wr_i,
	input	mem_pkg::addr_t		data_addr_i,
	input	mem_pkg::word_t		data_wdata_i,
	input	mem_pkg::byte_t		ram_rdata_i,
	output	logic				if_done_o,
	output	mem_pkg::word_t		if_word_o,
	output	logic				data_done_o,
	output	mem_pkg::word_t		data_rdata_o,
	output	mem_pkg::addr_t		ram_addr_o,
	output	logic				ram_we_o,
	output	mem_pkg::byte_t		ram_wdata_o
);

	mem_pkg::ctrl_state_t	state_q;
	logic [1:0]				cnt_q;
	logic					tail_q;

	logic					if_pend_q;
	logic					data_pend_q;
	mem_pkg::addr_t			if_addr_q;
	mem_pkg::addr_t			data_addr_q;
	logic					data_wr_q;
	mem_pkg::word_t			data_wdata_q;

	mem_pkg::addr_t			base_q;
	mem_pkg::word_t			wbuf_q;
	logic [23:0]			asm_q;

	logic					idle;
	logic					if_go;
	logic					data_go;
	mem_pkg::addr_t			if_addr_sel;
	mem_pkg::addr_t			data_addr_sel;
	logic					data_wr_sel;
	mem_pkg::word_t			data_wdata_sel;
	logic					busy_rd;
	mem_pkg::word_t			rd_word;

	assign idle = (state_q == mem_pkg::IDLE);

	// a strobe arriving while idle is taken at once, otherwise it waits in the latch
	assign if_go = if_pend_q | if_req_i;
	assign data_go = data_pend_q | data_req_i;

	assign if_addr_sel = if_req_i ? if_addr_i : if_addr_q;
	assign data_addr_sel = data_req_i ? data_addr_i : data_addr_q;
	assign data_wr_sel = data_req_i ? data_wr_i : data_wr_q;
	assign data_wdata_sel = data_req_i ? data_wdata_i : data_wdata_q;

	assign busy_rd = (state_q == mem_pkg::FETCH) || (state_q == mem_pkg::DATA_RD);

	// pending flags, data wins the arbitration in idle
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			if_pend_q <= 1'b0;
			data_pend_q <= 1'b0;
		end else begin
			if (idle && data_go) begin
				data_pend_q <= 1'b0;
			end else if (data_req_i) begin
				data_pend_q <= 1'b1;
			end
			if (idle && !data_go && if_go) begin
				if_pend_q <= 1'b0;
			end else if (if_req_i) begin
				if_pend_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (if_req_i) begin
			if_addr_q <= if_addr_i;
		end
		if (data_req_i) begin
			data_addr_q <= data_addr_i;
			data_wr_q <= data_wr_i;
			data_wdata_q <= data_wdata_i;
		end
	end

	// byte sequencer, a read needs one extra cycle for the last ram byte
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= mem_pkg::IDLE;
			cnt_q <= 2'd0;
			tail_q <= 1'b0;
		end else begin
			case (state_q)
				mem_pkg::IDLE: begin
					cnt_q <= 2'd0;
					tail_q <= 1'b0;
					if (data_go) begin
						state_q <= data_wr_sel ? mem_pkg::DATA_WR : mem_pkg::DATA_RD;
					end else if (if_go) begin
						state_q <= mem_pkg::FETCH;
					end
				end
				mem_pkg::DATA_WR: begin
					cnt_q <= cnt_q + 2'd1;
					if (cnt_q == 2'd3) begin
						state_q <= mem_pkg::IDLE;
					end
				end
				default: begin
					cnt_q <= cnt_q + 2'd1;
					if (cnt_q == 2'd3) begin
						tail_q <= 1'b1;
					end
					if (tail_q) begin
						tail_q <= 1'b0;
						state_q <= mem_pkg::IDLE;
					end
				end
			endcase
		end
	end

	// base address and write word are loaded on the grant
	always_ff @(posedge clk_i) begin
		if (idle) begin
			base_q <= data_go ? data_addr_sel : if_addr_sel;
			wbuf_q <= data_wdata_sel;
		end else if (state_q == mem_pkg::DATA_WR) begin
			wbuf_q <= {wbuf_q[23:0], 8'h00}; // next byte moves to the top
		end
		if (busy_rd) begin
			asm_q <= {asm_q[15:0], ram_rdata_i}; // stale bytes fall off the top
		end
	end

	assign rd_word = {asm_q, ram_rdata_i};

	assign ram_addr_o = base_q + mem_pkg::addr_t'(cnt_q);
	assign ram_we_o = (state_q == mem_pkg::DATA_WR);
	assign ram_wdata_o = wbuf_q[31:24];

	assign if_done_o = (state_q == mem_pkg::FETCH) && tail_q;
	assign if_word_o = rd_word;
	assign data_done_o = ((state_q == mem_pkg::DATA_RD) && tail_q) ||
		((state_q == mem_pkg::DATA_WR) && (cnt_q == 2'd3));
	assign data_rdata_o = rd_word;

endmodule

/* hw/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram #(
	parameter int ADDR_W = 10
) (
	input	logic				clk_i,
	input	mem_pkg::addr_t		addr_i,
	input	logic				we_i,
	input	mem_pkg::byte_t		wdata_i,
	output	mem_pkg::byte_t		rdata_o
);

	localparam int DEPTH = 2 ** ADDR_W;

	mem_pkg::byte_t		mem [DEPTH];
	logic [ADDR_W-1:0]	idx;

	assign idx = addr_i[ADDR_W-1:0]; // upper address bits are ignored so accesses wrap

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[idx] <= wdata_i;
		end
		rdata_o <= mem[idx]; // old contents on a same-cycle write
	end

endmodule

/* hw/mem_pkg.sv */
package mem_pkg;

	// one memory location
	typedef logic [7:0] byte_t;

	// words are stored big-endian, so the high byte sits at the lowest address
	typedef logic [31:0] word_t;

	// byte address, only the low bits reach the ram and the rest wrap
	typedef logic [31:0] addr_t;

	// controller phases, both read kinds share the same byte timing
	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		DATA_RD,
		DATA_WR
	} ctrl_state_t;

endpackage
